/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////

    localparam int OPCODE_W = 7;
    localparam int FUNC3_W  = 3;

    // RV32I major opcodes kept by this controller
    typedef enum logic [OPCODE_W-1:0]
    {
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // Decoded instruction kind
    typedef enum logic [2:0]
    {
        EX_NONE    = 3'd0,
        EX_ALU_REG = 3'd1,
        EX_ALU_IMM = 3'd2,
        EX_LOAD    = 3'd3,
        EX_STORE   = 3'd4,
        EX_BRANCH  = 3'd5
    } exec_class_t;

    typedef enum logic [1:0]
    {
        PC_PLUS4  = 2'b00,
        PC_BRANCH = 2'b01
    } pc_sel_t;

    // Register file write source
    typedef enum logic [1:0]
    {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01
    } wb_sel_t;

    // One-hot access width
    typedef enum logic [2:0]
    {
        MW_NONE = 3'b000,
        MW_BYTE = 3'b001,
        MW_HALF = 3'b010,
        MW_WORD = 3'b100
    } mem_width_t;

    ////////////////////////////////////////////////////////////
    // Port groups
    ////////////////////////////////////////////////////////////

    typedef struct packed
    {
        opcode_t              opcode;
        logic [FUNC3_W-1:0]   func3;
    } instr_fields_t;

    typedef struct packed
    {
        logic       ir_en;      // Instruction register load
        logic       pc_en;      // PC load
        pc_sel_t    pc_select;
        logic       alu_src;    // ALU operand b from immediate
        logic       reg_write;
        wb_sel_t    mem_to_reg;
        mem_width_t mem_width;
        logic       mem_read;
        logic       mem_write;
    } ctrl_t;

    // All controls inactive
    localparam ctrl_t CTRL_NONE = '0;

endpackage

/* verilog/instr_sequencer.sv */
`timescale 1ns/1ns

module instr_sequencer
(
    input  logic              clk,
    input  logic              reset,
    input  logic              go,
    input  ctrl_pkg::opcode_t opcode,
    input  ctrl_pkg::ctrl_t   alu_ctrl,
    input  ctrl_pkg::ctrl_t   mem_ctrl,
    input  ctrl_pkg::ctrl_t   br_ctrl,
    input  logic              alu_finish,
    input  logic              mem_finish,
    input  logic              br_finish,
    output logic              alu_start,
    output logic              mem_start,
    output logic              br_start,
    output logic              alu_use_imm,
    output ctrl_pkg::ctrl_t   ctrl,
    output logic              done
);

    import ctrl_pkg::*;

    typedef enum logic [2:0]
    {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_PC_UPDATE,
        SEQ_DECODE,
        SEQ_EXECUTE,
        SEQ_DONE
    } seq_state_t;

    seq_state_t  state;
    seq_state_t  state_nxt;
    exec_class_t decode_class;  // Class of the instruction being decoded
    exec_class_t exec_class;    // Class latched for the execute phase
    ctrl_t       seq_ctrl;
    logic        unit_finish;

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (opcode)
            OP_RTYPE:  decode_class = EX_ALU_REG;
            OP_ITYPE:  decode_class = EX_ALU_IMM;
            OP_LOAD:   decode_class = EX_LOAD;
            OP_STORE:  decode_class = EX_STORE;
            OP_BRANCH: decode_class = EX_BRANCH;
            default:   decode_class = EX_NONE;  // Unknown opcode retires quietly
        endcase
    end

    // Start pulses only in the decode cycle
    assign alu_start   = (state == SEQ_DECODE) &&
                         (decode_class == EX_ALU_REG || decode_class == EX_ALU_IMM);
    assign mem_start   = (state == SEQ_DECODE) &&
                         (decode_class == EX_LOAD || decode_class == EX_STORE);
    assign br_start    = (state == SEQ_DECODE) && (decode_class == EX_BRANCH);
    assign alu_use_imm = (decode_class == EX_ALU_IMM);

    // Finish of the unit that owns the current instruction
    always_comb
    begin
        case (exec_class)
            EX_ALU_REG, EX_ALU_IMM: unit_finish = alu_finish;
            EX_LOAD, EX_STORE:      unit_finish = mem_finish;
            EX_BRANCH:              unit_finish = br_finish;
            default:                unit_finish = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            SEQ_IDLE:
            begin
                if (go)
                begin
                    state_nxt = SEQ_FETCH;
                end
            end
            SEQ_FETCH:     state_nxt = SEQ_PC_UPDATE;
            SEQ_PC_UPDATE: state_nxt = SEQ_DECODE;
            SEQ_DECODE:
            begin
                // Nothing to execute means done in this very cycle
                state_nxt = (decode_class == EX_NONE) ? SEQ_IDLE : SEQ_EXECUTE;
            end
            SEQ_EXECUTE:
            begin
                if (unit_finish)
                begin
                    state_nxt = SEQ_DONE;
                end
            end
            SEQ_DONE:      state_nxt = SEQ_IDLE;
            default:       state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= SEQ_IDLE;
            exec_class <= EX_NONE;
        end
        else
        begin
            state <= state_nxt;
            if (state == SEQ_DECODE)
            begin
                exec_class <= decode_class;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        seq_ctrl           = CTRL_NONE;
        seq_ctrl.ir_en     = (state == SEQ_FETCH);
        seq_ctrl.pc_en     = (state == SEQ_PC_UPDATE);
        seq_ctrl.pc_select = PC_PLUS4;
    end

    // Idle units hold all-zero controls, so an OR merges them
    assign ctrl = ctrl_t'(seq_ctrl | alu_ctrl | mem_ctrl | br_ctrl);

    assign done = (state == SEQ_DONE) ||
                  (state == SEQ_DECODE && decode_class == EX_NONE);

    // At most one execution unit is launched per instruction
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_start, mem_start, br_start}))
    else
        $error("More than one execution unit started");

endmodule

/* verilog/alu_exec_fsm.sv */
`timescale 1ns/1ns

module alu_exec_fsm
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            use_imm,
    output ctrl_pkg::ctrl_t ctrl,
    output logic            finish
);

    import ctrl_pkg::*;

    typedef enum logic [1:0]
    {
        ALU_IDLE,
        ALU_WRITE,
        ALU_FINISH
    } alu_state_t;

    alu_state_t state;
    alu_state_t state_nxt;
    ctrl_t      ctrl_nxt;

    always_comb
    begin
        state_nxt = state;
        ctrl_nxt  = CTRL_NONE;
        case (state)
            ALU_IDLE:
            begin
                if (start)
                begin
                    state_nxt           = ALU_WRITE;
                    ctrl_nxt.alu_src    = use_imm;   // 0 register, 1 immediate
                    ctrl_nxt.reg_write  = 1'b1;
                    ctrl_nxt.mem_to_reg = WB_ALU;
                end
            end
            ALU_WRITE:
            begin
                // Keep the operand source one more cycle
                state_nxt           = ALU_FINISH;
                ctrl_nxt.alu_src    = ctrl.alu_src;
                ctrl_nxt.mem_to_reg = WB_ALU;
            end
            default:  state_nxt = ALU_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ALU_IDLE;
            ctrl  <= CTRL_NONE;
        end
        else
        begin
            state <= state_nxt;
            ctrl  <= ctrl_nxt;
        end
    end

    assign finish = (state == ALU_FINISH);

    // Single write per instruction
    assert property (@(posedge clk) disable iff (reset)
        ctrl.reg_write |=> !ctrl.reg_write)
    else
        $error("ALU register write held for two cycles");

endmodule

/* verilog/mem_access_fsm.sv */
`timescale 1ns/1ns

module mem_access_fsm
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  ctrl_pkg::opcode_t            opcode,
    input  logic [ctrl_pkg::FUNC3_W-1:0] func3,
    output ctrl_pkg::ctrl_t              ctrl,
    output logic                         finish
);

    import ctrl_pkg::*;

    typedef enum logic [1:0]
    {
        MEM_IDLE,
        MEM_ACCESS,
        MEM_WRITEBACK,
        MEM_FINISH
    } mem_state_t;

    mem_state_t state;
    mem_state_t state_nxt;
    ctrl_t      ctrl_nxt;
    mem_width_t width_sel;
    logic       is_load;
    logic       load_op;   // Load seen at start

    ////////////////////////////////////////////////////////////
    // Width decode
    ////////////////////////////////////////////////////////////

    assign is_load = (opcode == OP_LOAD);

    always_comb
    begin
        width_sel = MW_NONE;
        if (is_load)
        begin
            case (func3)
                3'd0, 3'd4: width_sel = MW_BYTE;   // LB, LBU
                3'd1, 3'd5: width_sel = MW_HALF;   // LH, LHU
                3'd2:       width_sel = MW_WORD;
                default:    width_sel = MW_NONE;
            endcase
        end
        else if (opcode == OP_STORE)
        begin
            case (func3)
                3'd0:    width_sel = MW_BYTE;
                3'd1:    width_sel = MW_HALF;
                3'd2:    width_sel = MW_WORD;
                default: width_sel = MW_NONE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Access sequence
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        ctrl_nxt  = CTRL_NONE;
        case (state)
            MEM_IDLE:
            begin
                if (start)
                begin
                    if (width_sel == MW_NONE)
                    begin
                        state_nxt = MEM_FINISH;     // Unsupported width drives nothing
                    end
                    else
                    begin
                        state_nxt          = MEM_ACCESS;
                        ctrl_nxt.alu_src   = 1'b1;  // Address is base plus offset
                        ctrl_nxt.mem_width = width_sel;
                        ctrl_nxt.mem_read  = is_load;
                        ctrl_nxt.mem_write = !is_load;
                    end
                end
            end
            MEM_ACCESS:
            begin
                ctrl_nxt.alu_src = 1'b1;
                if (load_op)
                begin
                    state_nxt           = MEM_WRITEBACK;
                    ctrl_nxt.reg_write  = 1'b1;
                    ctrl_nxt.mem_to_reg = WB_MEM;
                end
                else
                begin
                    state_nxt = MEM_FINISH;
                end
            end
            MEM_WRITEBACK:
            begin
                state_nxt        = MEM_FINISH;
                ctrl_nxt.alu_src = 1'b1;
            end
            default: state_nxt = MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= MEM_IDLE;
            ctrl    <= CTRL_NONE;
            load_op <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            ctrl  <= ctrl_nxt;
            if (state == MEM_IDLE && start)
            begin
                load_op <= is_load;
            end
        end
    end

    assign finish = (state == MEM_FINISH);

    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_read && ctrl.mem_write))
    else
        $error("Memory read and write strobes together");

    assert property (@(posedge clk) disable iff (reset)
        (ctrl.mem_read || ctrl.mem_write) |-> ctrl.mem_width != MW_NONE)
    else
        $error("Memory access without a width");

endmodule

/* verilog/branch_fsm.sv */
`timescale 1ns/1ns

module branch_fsm
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            comparator,
    output ctrl_pkg::ctrl_t ctrl,
    output logic            finish
);

    import ctrl_pkg::*;

    typedef enum logic [1:0]
    {
        BR_IDLE,
        BR_RESOLVE,
        BR_FINISH
    } br_state_t;

    br_state_t state;
    br_state_t state_nxt;
    ctrl_t     ctrl_nxt;

    always_comb
    begin
        state_nxt = state;
        ctrl_nxt  = CTRL_NONE;
        case (state)
            BR_IDLE:
            begin
                if (start)
                begin
                    state_nxt = BR_RESOLVE;
                    if (comparator)
                    begin
                        ctrl_nxt.pc_en     = 1'b1;
                        ctrl_nxt.pc_select = PC_BRANCH;
                    end
                end
            end
            BR_RESOLVE: state_nxt = BR_FINISH;   // Taken or quiet cycle
            default:    state_nxt = BR_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= BR_IDLE;
            ctrl  <= CTRL_NONE;
        end
        else
        begin
            state <= state_nxt;
            ctrl  <= ctrl_nxt;
        end
    end

    assign finish = (state == BR_FINISH);

    // This unit only ever loads the branch target
    assert property (@(posedge clk) disable iff (reset)
        ctrl.pc_en |-> ctrl.pc_select == PC_BRANCH)
    else
        $error("Branch unit PC load without branch select");

endmodule

/* verilog/cpu_controller.sv */
`timescale 1ns/1ns

module cpu_controller
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    go,
    input  ctrl_pkg::instr_fields_t instr,
    input  logic                    comparator,
    output ctrl_pkg::ctrl_t         ctrl,
    output logic                    done
);

    import ctrl_pkg::*;

    ctrl_t alu_ctrl;
    ctrl_t mem_ctrl;
    ctrl_t br_ctrl;
    logic  alu_start;
    logic  mem_start;
    logic  br_start;
    logic  alu_finish;
    logic  mem_finish;
    logic  br_finish;
    logic  alu_use_imm;

    ////////////////////////////////////////////////////////////
    // Main sequencer
    ////////////////////////////////////////////////////////////

    instr_sequencer u_seq
    (
        .clk         (clk),
        .reset       (reset),
        .go          (go),
        .opcode      (instr.opcode),
        .alu_ctrl    (alu_ctrl),
        .mem_ctrl    (mem_ctrl),
        .br_ctrl     (br_ctrl),
        .alu_finish  (alu_finish),
        .mem_finish  (mem_finish),
        .br_finish   (br_finish),
        .alu_start   (alu_start),
        .mem_start   (mem_start),
        .br_start    (br_start),
        .alu_use_imm (alu_use_imm),
        .ctrl        (ctrl),
        .done        (done)
    );

    ////////////////////////////////////////////////////////////
    // Execution units
    ////////////////////////////////////////////////////////////

    alu_exec_fsm u_alu
    (
        .clk     (clk),
        .reset   (reset),
        .start   (alu_start),
        .use_imm (alu_use_imm),
        .ctrl    (alu_ctrl),
        .finish  (alu_finish)
    );

    mem_access_fsm u_mem
    (
        .clk    (clk),
        .reset  (reset),
        .start  (mem_start),
        .opcode (instr.opcode),
        .func3  (instr.func3),
        .ctrl   (mem_ctrl),
        .finish (mem_finish)
    );

    branch_fsm u_br
    (
        .clk        (clk),
        .reset      (reset),
        .start      (br_start),
        .comparator (comparator),   // Held stable by the host until done
        .ctrl       (br_ctrl),
        .finish     (br_finish)
    );

endmodule

/* test/tb_cpu_controller.sv */
`timescale 1ns/1ns

module tb_cpu_controller;

    import ctrl_pkg::*;

    // What one instruction should produce
    typedef struct packed
    {
        logic [4:0] latency;    // Cycles from go to done
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       taken;
        mem_width_t width;
        wb_sel_t    wb;
        logic       alu_src;
    } expect_t;

    logic          clk;
    logic          reset;
    logic          go;
    instr_fields_t instr;
    logic          comparator;
    ctrl_t         ctrl;
    logic          done;
    logic          started;     // First go has been driven
    expect_t       exp_cur;
    logic [31:0]   rnd;

    cpu_controller u_dut
    (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .instr      (instr),
        .comparator (comparator),
        .ctrl       (ctrl),
        .done       (done)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("mismatch at %0t ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [6:0] pick_opcode(input int idx);
        case (idx)
            0:       return OP_RTYPE;
            1:       return OP_ITYPE;
            2:       return OP_LOAD;
            3:       return OP_STORE;
            4:       return OP_BRANCH;
            default: return 7'b1101111;     // JAL is not handled by the controller
        endcase
    endfunction

    // Reference rules per instruction class
    function automatic expect_t expected_for(input logic [6:0] op, input logic [2:0] f3,
                                             input logic cmp);
        expect_t e;
        e         = '0;
        e.latency = 5'd3;                   // Unknown opcode retires at decode
        case (op)
            OP_RTYPE, OP_ITYPE:
            begin
                e.latency   = 5'd6;
                e.reg_write = 1'b1;
                e.wb        = WB_ALU;
                e.alu_src   = (op == OP_ITYPE);
            end
            OP_LOAD:
            begin
                if (f3 == 3'd0 || f3 == 3'd4)      e.width = MW_BYTE;
                else if (f3 == 3'd1 || f3 == 3'd5) e.width = MW_HALF;
                else if (f3 == 3'd2)               e.width = MW_WORD;
                e.latency   = (e.width == MW_NONE) ? 5'd5 : 5'd7;
                e.mem_read  = (e.width != MW_NONE);
                e.reg_write = (e.width != MW_NONE);
                e.wb        = WB_MEM;
                e.alu_src   = 1'b1;
            end
            OP_STORE:
            begin
                if (f3 == 3'd0)      e.width = MW_BYTE;
                else if (f3 == 3'd1) e.width = MW_HALF;
                else if (f3 == 3'd2) e.width = MW_WORD;
                e.latency   = (e.width == MW_NONE) ? 5'd5 : 5'd6;
                e.mem_write = (e.width != MW_NONE);
                e.alu_src   = 1'b1;
            end
            OP_BRANCH:
            begin
                e.latency = 5'd6;
                e.taken   = cmp;
            end
            default: e.latency = 5'd3;
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) (reset || !started) |-> (ctrl == CTRL_NONE && !done))
    else
        report_mismatch("controls or done active before the first instruction");

    // Fetch cycle, then the PC+4 cycle
    assert property (@(posedge clk) disable iff (reset)
        go |=> (ctrl.ir_en && !ctrl.pc_en) ##1
               (ctrl.pc_en && ctrl.pc_select == PC_PLUS4 && !ctrl.ir_en))
    else
        report_mismatch("fetch and PC update sequence wrong");

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
        report_mismatch("done longer than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        (ctrl.mem_read || ctrl.mem_write) |-> (ctrl.mem_width == exp_cur.width && ctrl.alu_src))
    else
        report_mismatch($sformatf("access width %b, expected %b", ctrl.mem_width, exp_cur.width));

    assert property (@(posedge clk) disable iff (reset)
        ctrl.reg_write |-> (ctrl.mem_to_reg == exp_cur.wb && ctrl.alu_src == exp_cur.alu_src))
    else
        report_mismatch("register write with wrong source or operand select");

    // Load access is followed by its write-back
    assert property (@(posedge clk) disable iff (reset)
        ctrl.mem_read |=> (ctrl.reg_write && ctrl.mem_to_reg == WB_MEM))
    else
        report_mismatch("load access not followed by the memory write-back");

    // Operand select still held in the unit's last cycle
    assert property (@(posedge clk) disable iff (reset)
        (ctrl.reg_write || ctrl.mem_write) |=> ctrl.alu_src == exp_cur.alu_src)
    else
        report_mismatch("operand select not held until the unit finishes");

    assert property (@(posedge clk) disable iff (reset)
        (ctrl.pc_en && ctrl.pc_select == PC_BRANCH) |-> exp_cur.taken)
    else
        report_mismatch("branch PC load on a path that should not branch");

    ////////////////////////////////////////////////////////////
    // One instruction, go to done
    ////////////////////////////////////////////////////////////

    task automatic run_instr(input logic [6:0] op, input logic [2:0] f3, input logic cmp);
        int   cycles;
        int   n_ir;
        int   n_plus4;
        int   n_branch;
        int   n_reg;
        int   n_read;
        int   n_write;
        logic got_done;
        @(posedge clk);
        #2;
        exp_cur      = expected_for(op, f3, cmp);
        instr.opcode = opcode_t'(op);
        instr.func3  = f3;
        comparator   = cmp;
        go           = 1'b1;
        started      = 1'b1;
        @(posedge clk);
        #2;
        go       = 1'b0;
        cycles   = 0;
        n_ir     = 0;
        n_plus4  = 0;
        n_branch = 0;
        n_reg    = 0;
        n_read   = 0;
        n_write  = 0;
        got_done = 1'b0;
        while (!got_done && cycles < 20)
        begin
            @(negedge clk);                 // Outputs settled mid-cycle
            cycles++;
            n_ir     += ctrl.ir_en;
            n_plus4  += (ctrl.pc_en && ctrl.pc_select == PC_PLUS4);
            n_branch += (ctrl.pc_en && ctrl.pc_select == PC_BRANCH);
            n_reg    += ctrl.reg_write;
            n_read   += ctrl.mem_read;
            n_write  += ctrl.mem_write;
            got_done  = done;
        end
        if (!got_done)
            fail_run($sformatf("Timeout: no done within 20 cycles for opcode %b", op));
        else
        begin
            assert (cycles == int'(exp_cur.latency))
            else
                report_mismatch($sformatf("latency %0d, expected %0d for opcode %b func3 %0d",
                                          cycles, exp_cur.latency, op, f3));
            assert (n_ir == 1 && n_plus4 == 1)
            else
                report_mismatch($sformatf("ir_en %0d and PC+4 %0d cycles", n_ir, n_plus4));
            assert (n_reg == int'(exp_cur.reg_write))
            else
                report_mismatch($sformatf("%0d register writes for opcode %b", n_reg, op));
            assert (n_read == int'(exp_cur.mem_read) && n_write == int'(exp_cur.mem_write))
            else
                report_mismatch($sformatf("%0d reads and %0d writes for opcode %b func3 %0d",
                                          n_read, n_write, op, f3));
            assert (n_branch == int'(exp_cur.taken))
            else
                report_mismatch($sformatf("%0d branch PC loads, comparator %b", n_branch, cmp));
        end
    endtask

    initial
    begin
        logic [6:0] op;
        logic [2:0] f3;
        logic       cmp;
        clk        = 1'b0;
        reset      = 1'b0;
        go         = 1'b0;
        instr      = '0;
        comparator = 1'b0;
        started    = 1'b0;
        exp_cur    = '0;
        rnd        = 32'h4c37;
        #2;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < 300; i++)
        begin
            rnd = lcg_next(rnd);
            op  = pick_opcode((rnd >> 16) % 6);
            rnd = lcg_next(rnd);
            f3  = rnd[26:24];
            cmp = rnd[30];
            run_instr(op, f3, cmp);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

/* project.f */
verilog/ctrl_pkg.sv
verilog/instr_sequencer.sv
verilog/alu_exec_fsm.sv
verilog/mem_access_fsm.sv
verilog/branch_fsm.sv
verilog/cpu_controller.sv
test/tb_cpu_controller.sv
